// File: verilog/csr_pkg.sv
package csr_pkg;

  localparam int xlen = 32;

  typedef enum logic [2:0] {
    csr_none = 3'd0,
    csr_rw   = 3'd1,
    csr_rs   = 3'd2,
    csr_rc   = 3'd3
  } csr_op_t;

  // machine csr addresses
  localparam logic [11:0] csr_addr_misa      = 12'h301;
  localparam logic [11:0] csr_addr_mvendorid = 12'hf11;
  localparam logic [11:0] csr_addr_marchid   = 12'hf12;
  localparam logic [11:0] csr_addr_mimpid    = 12'hf13;
  localparam logic [11:0] csr_addr_mhartid   = 12'hf14;
  localparam logic [11:0] csr_addr_mstatus   = 12'h300;
  localparam logic [11:0] csr_addr_mie       = 12'h304;
  localparam logic [11:0] csr_addr_mtvec     = 12'h305;
  localparam logic [11:0] csr_addr_mscratch  = 12'h340;
  localparam logic [11:0] csr_addr_mepc      = 12'h341;
  localparam logic [11:0] csr_addr_mcause    = 12'h342;
  localparam logic [11:0] csr_addr_mtval     = 12'h343;
  localparam logic [11:0] csr_addr_mip       = 12'h344;
  localparam logic [11:0] csr_addr_mcycle    = 12'hb00;
  localparam logic [11:0] csr_addr_mcycleh   = 12'hb80;
  localparam logic [11:0] csr_addr_minstret  = 12'hb02;
  localparam logic [11:0] csr_addr_minstreth = 12'hb82;

  localparam logic [6:0] opcode_system = 7'b1110011;

  localparam logic [2:0] funct3_priv   = 3'b000;
  localparam logic [2:0] funct3_csrrw  = 3'b001;
  localparam logic [2:0] funct3_csrrs  = 3'b010;
  localparam logic [2:0] funct3_csrrc  = 3'b011;
  localparam logic [2:0] funct3_csrrwi = 3'b101;
  localparam logic [2:0] funct3_csrrsi = 3'b110;
  localparam logic [2:0] funct3_csrrci = 3'b111;

  localparam logic [11:0] funct12_ecall  = 12'h000;
  localparam logic [11:0] funct12_ebreak = 12'h001;
  localparam logic [11:0] funct12_mret   = 12'h302;

  localparam logic [3:0] cause_illegal    = 4'd2;
  localparam logic [3:0] cause_breakpoint = 4'd3;
  localparam logic [3:0] cause_ecall_m    = 4'd11;

  localparam logic [3:0] irq_mach_soft   = 4'd3;
  localparam logic [3:0] irq_mach_timer  = 4'd7;
  localparam logic [3:0] irq_mach_extern = 4'd11;

  localparam logic [1:0] u_mode = 2'b00;
  localparam logic [1:0] m_mode = 2'b11;

  // mxl=1, extensions i m f c
  localparam logic [31:0] misa_value = 32'h4000_1124;

  localparam logic [31:0] mtvec_reset = 32'h0000_0000;
  localparam logic [1:0]  mpp_reset   = m_mode;

endpackage

// File: verilog/csr_decode.sv
`timescale 1ns/1ps

module csr_decode (
  input  logic                      instr_valid,
  input  logic [csr_pkg::xlen-1:0]  instr,
  output csr_pkg::csr_op_t          csr_op,
  output logic                      use_imm,
  output logic                      rs1_nonzero,
  output logic                      csr_rd_en,
  output logic                      exc_req,
  output logic                      mret_req,
  output logic [4:0]                zimm,
  output logic [4:0]                rd_addr,
  output logic [11:0]               csr_addr,
  output logic [3:0]                exc_cause
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;

  assign opcode      = instr[6:0];
  assign funct3      = instr[14:12];
  assign funct12     = instr[31:20];
  assign rd_addr     = instr[11:7];
  assign csr_addr    = instr[31:20];
  assign zimm        = instr[19:15];   // rs1 field doubles as uimm
  assign rs1_nonzero = |instr[19:15];
  assign use_imm     = funct3[2];

  always_comb begin
    csr_op    = csr_pkg::csr_none;
    csr_rd_en = 1'b0;
    exc_req   = 1'b0;
    mret_req  = 1'b0;
    exc_cause = csr_pkg::cause_illegal;
    if (instr_valid) begin
      if (opcode == csr_pkg::opcode_system) begin
        case (funct3)
          csr_pkg::funct3_priv: begin
            case (funct12)
              csr_pkg::funct12_ecall: begin
                exc_req   = 1'b1;
                exc_cause = csr_pkg::cause_ecall_m;
              end
              csr_pkg::funct12_ebreak: begin
                exc_req   = 1'b1;
                exc_cause = csr_pkg::cause_breakpoint;
              end
              csr_pkg::funct12_mret: mret_req = 1'b1;
              default: exc_req = 1'b1;
            endcase
          end
          csr_pkg::funct3_csrrw, csr_pkg::funct3_csrrwi: begin
            csr_op    = csr_pkg::csr_rw;
            csr_rd_en = |instr[11:7];   // no csr read side effect for rd=x0
          end
          csr_pkg::funct3_csrrs, csr_pkg::funct3_csrrsi: begin
            csr_op    = csr_pkg::csr_rs;
            csr_rd_en = 1'b1;
          end
          csr_pkg::funct3_csrrc, csr_pkg::funct3_csrrci: begin
            csr_op    = csr_pkg::csr_rc;
            csr_rd_en = 1'b1;
          end
          default: exc_req = 1'b1;
        endcase
      end else begin
        exc_req = 1'b1;   // only SYSTEM instructions reach this unit
      end
    end
  end

endmodule

// File: verilog/csr_execute.sv
`timescale 1ns/1ps

module csr_execute (
  input  csr_pkg::csr_op_t          csr_op,
  input  logic                      use_imm,
  input  logic                      rs1_nonzero,
  input  logic [4:0]                zimm,
  input  logic [csr_pkg::xlen-1:0]  rs1_data,
  input  logic [csr_pkg::xlen-1:0]  csr_rdata,
  output logic                      csr_wen,
  output logic [csr_pkg::xlen-1:0]  csr_wdata
);

  logic [csr_pkg::xlen-1:0] operand;

  assign operand = use_imm ? {{(csr_pkg::xlen-5){1'b0}}, zimm} : rs1_data;

  always_comb begin
    csr_wen   = 1'b0;
    csr_wdata = csr_rdata;
    case (csr_op)
      csr_pkg::csr_rw: begin
        csr_wen   = 1'b1;
        csr_wdata = operand;
      end
      csr_pkg::csr_rs: begin
        csr_wen   = rs1_nonzero;   // csrrs x0 is a pure read
        csr_wdata = csr_rdata | operand;
      end
      csr_pkg::csr_rc: begin
        csr_wen   = rs1_nonzero;
        csr_wdata = csr_rdata & ~operand;
      end
      default: begin
        csr_wen   = 1'b0;
        csr_wdata = csr_rdata;
      end
    endcase
  end

endmodule

// File: verilog/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid,
  input  logic [csr_pkg::xlen-1:0]  pc,
  input  logic [11:0]               csr_addr,
  input  logic                      csr_wen,
  input  logic [csr_pkg::xlen-1:0]  csr_wdata,
  input  logic                      exc_req,
  input  logic                      mret_req,
  input  logic [3:0]                exc_cause,
  input  logic                      meip,
  input  logic                      mtip,
  input  logic                      msip,
  output logic [csr_pkg::xlen-1:0]  csr_rdata,
  output logic                      trap_take,
  output logic                      trap,
  output logic                      mret,
  output logic [csr_pkg::xlen-1:0]  trap_vector,
  output logic [csr_pkg::xlen-1:0]  mepc
);

  logic                       st_mie;
  logic                       st_mpie;
  logic [1:0]                 st_mpp;
  logic [1:0]                 st_fs;
  logic                       ie_meie;
  logic                       ie_mtie;
  logic                       ie_msie;
  logic                       ip_meip;
  logic                       ip_mtip;
  logic                       ip_msip;
  logic [csr_pkg::xlen-1:0]   mtvec;
  logic [csr_pkg::xlen-1:0]   mscratch;
  logic [csr_pkg::xlen-1:0]   mcause;
  logic [csr_pkg::xlen-1:0]   mtval;
  logic [2*csr_pkg::xlen-1:0] mcycle;
  logic [2*csr_pkg::xlen-1:0] minstret;
  logic [csr_pkg::xlen-1:0]   trap_cause;
  logic                       wr_en;

  // exception first, then external, timer, software
  always_comb begin
    trap_take  = 1'b0;
    trap_cause = {28'h0, exc_cause};
    if (st_mie) begin
      if (exc_req) begin
        trap_take = 1'b1;
      end else if (instr_valid && ie_meie && ip_meip) begin
        trap_take  = 1'b1;
        trap_cause = {1'b1, 27'h0, csr_pkg::irq_mach_extern};
      end else if (instr_valid && ie_mtie && ip_mtip) begin
        trap_take  = 1'b1;
        trap_cause = {1'b1, 27'h0, csr_pkg::irq_mach_timer};
      end else if (instr_valid && ie_msie && ip_msip) begin
        trap_take  = 1'b1;
        trap_cause = {1'b1, 27'h0, csr_pkg::irq_mach_soft};
      end
    end
  end

  assign wr_en = csr_wen && !trap_take;

  always_comb begin
    case (csr_addr)
      csr_pkg::csr_addr_misa:      csr_rdata = csr_pkg::misa_value;
      csr_pkg::csr_addr_mstatus:   csr_rdata = {(st_fs == 2'b11), 16'h0, st_fs, st_mpp,
                                                3'b000, st_mpie, 3'b000, st_mie, 3'b000};
      csr_pkg::csr_addr_mie:       csr_rdata = {20'h0, ie_meie, 3'b000, ie_mtie, 3'b000,
                                                ie_msie, 3'b000};
      csr_pkg::csr_addr_mip:       csr_rdata = {20'h0, ip_meip, 3'b000, ip_mtip, 3'b000,
                                                ip_msip, 3'b000};
      csr_pkg::csr_addr_mtvec:     csr_rdata = mtvec;
      csr_pkg::csr_addr_mscratch:  csr_rdata = mscratch;
      csr_pkg::csr_addr_mepc:      csr_rdata = mepc;
      csr_pkg::csr_addr_mcause:    csr_rdata = mcause;
      csr_pkg::csr_addr_mtval:     csr_rdata = mtval;
      csr_pkg::csr_addr_mcycle:    csr_rdata = mcycle[csr_pkg::xlen-1:0];
      csr_pkg::csr_addr_mcycleh:   csr_rdata = mcycle[2*csr_pkg::xlen-1:csr_pkg::xlen];
      csr_pkg::csr_addr_minstret:  csr_rdata = minstret[csr_pkg::xlen-1:0];
      csr_pkg::csr_addr_minstreth: csr_rdata = minstret[2*csr_pkg::xlen-1:csr_pkg::xlen];
      default:                     csr_rdata = '0;   // id registers read zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      st_mie   <= 1'b0;
      st_mpie  <= 1'b0;
      st_mpp   <= csr_pkg::mpp_reset;
      st_fs    <= 2'b00;
      ie_meie  <= 1'b0;
      ie_mtie  <= 1'b0;
      ie_msie  <= 1'b0;
      ip_meip  <= 1'b0;
      ip_mtip  <= 1'b0;
      ip_msip  <= 1'b0;
      mtvec    <= csr_pkg::mtvec_reset;
      mcycle   <= '0;
      minstret <= '0;
      trap     <= 1'b0;
      mret     <= 1'b0;
    end else begin
      ip_meip <= meip;
      ip_mtip <= mtip;
      ip_msip <= msip;
      mcycle  <= mcycle + 1'b1;
      trap    <= trap_take;
      mret    <= mret_req && !trap_take;
      if (instr_valid && !trap_take) begin
        minstret <= minstret + 1'b1;
      end
      if (wr_en) begin
        case (csr_addr)
          csr_pkg::csr_addr_mstatus: begin
            st_fs   <= csr_wdata[14:13];
            st_mpie <= csr_wdata[7];
            st_mie  <= csr_wdata[3];
            if (csr_wdata[12:11] == csr_pkg::m_mode || csr_wdata[12:11] == csr_pkg::u_mode) begin
              st_mpp <= csr_wdata[12:11];
            end
          end
          csr_pkg::csr_addr_mie: begin
            ie_meie <= csr_wdata[11];
            ie_mtie <= csr_wdata[7];
            ie_msie <= csr_wdata[3];
          end
          csr_pkg::csr_addr_mtvec:     mtvec <= csr_wdata;
          csr_pkg::csr_addr_mcycle:    mcycle[csr_pkg::xlen-1:0] <= csr_wdata;
          csr_pkg::csr_addr_mcycleh:   mcycle[2*csr_pkg::xlen-1:csr_pkg::xlen] <= csr_wdata;
          csr_pkg::csr_addr_minstret:  minstret[csr_pkg::xlen-1:0] <= csr_wdata;
          csr_pkg::csr_addr_minstreth: minstret[2*csr_pkg::xlen-1:csr_pkg::xlen] <= csr_wdata;
          default: ;
        endcase
      end
      if (trap_take) begin
        st_mpie <= st_mie;
        st_mie  <= 1'b0;
      end else if (mret_req) begin
        st_mie  <= st_mpie;
        st_mpie <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (trap_take) begin
      mepc   <= pc;
      mtval  <= '0;
      mcause <= trap_cause;
    end else if (wr_en) begin
      case (csr_addr)
        csr_pkg::csr_addr_mscratch: mscratch <= csr_wdata;
        csr_pkg::csr_addr_mepc:     mepc <= csr_wdata;
        csr_pkg::csr_addr_mcause:   mcause <= csr_wdata;
        csr_pkg::csr_addr_mtval:    mtval <= csr_wdata;
        default: ;
      endcase
    end
  end

  // vectored mode adds 4*cause to the base
  assign trap_vector = (mtvec[1:0] == 2'b01) ?
      {mtvec[csr_pkg::xlen-1:2] + {{(csr_pkg::xlen-6){1'b0}}, mcause[3:0]}, 2'b00} :
      {mtvec[csr_pkg::xlen-1:2], 2'b00};

endmodule

// File: verilog/csr_result.sv
`timescale 1ns/1ps

module csr_result (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid,
  input  logic                      csr_rd_en,
  input  logic                      trap_take,
  input  logic [4:0]                rd_addr_in,
  input  logic [csr_pkg::xlen-1:0]  csr_rdata,
  input  logic                      trap,
  input  logic                      mret,
  input  logic [csr_pkg::xlen-1:0]  trap_vector,
  input  logic [csr_pkg::xlen-1:0]  mepc,
  output logic                      rd_we,
  output logic [4:0]                rd_addr,
  output logic [csr_pkg::xlen-1:0]  rd_data,
  output logic                      redirect,
  output logic [csr_pkg::xlen-1:0]  redirect_pc
);

  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_we <= 1'b0;
    end else begin
      rd_we <= instr_valid && csr_rd_en && !trap_take && (rd_addr_in != 5'd0);
    end
  end

  always_ff @(posedge clk) begin
    rd_addr <= rd_addr_in;
    rd_data <= csr_rdata;   // old csr value
  end

  // trap and mret already arrive one cycle after the instruction
  assign redirect    = trap | mret;
  assign redirect_pc = trap ? trap_vector : mepc;

endmodule

// File: verilog/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_valid,
  input  logic [csr_pkg::xlen-1:0]  instr,
  input  logic [csr_pkg::xlen-1:0]  rs1_data,
  input  logic [csr_pkg::xlen-1:0]  pc,
  input  logic                      meip,
  input  logic                      mtip,
  input  logic                      msip,
  output logic                      rd_we,
  output logic [4:0]                rd_addr,
  output logic [csr_pkg::xlen-1:0]  rd_data,
  output logic                      redirect,
  output logic [csr_pkg::xlen-1:0]  redirect_pc
);

  csr_pkg::csr_op_t          csr_op;
  logic                      use_imm;
  logic                      rs1_nonzero;
  logic                      csr_rd_en;
  logic                      exc_req;
  logic                      mret_req;
  logic [4:0]                zimm;
  logic [4:0]                dec_rd_addr;
  logic [11:0]               csr_addr;
  logic [3:0]                exc_cause;
  logic                      csr_wen;
  logic [csr_pkg::xlen-1:0]  csr_wdata;
  logic [csr_pkg::xlen-1:0]  csr_rdata;
  logic                      trap_take;
  logic                      trap;
  logic                      mret;
  logic [csr_pkg::xlen-1:0]  trap_vector;
  logic [csr_pkg::xlen-1:0]  mepc;

  csr_decode u_csr_decode (
    .instr_valid (instr_valid),
    .instr       (instr),
    .csr_op      (csr_op),
    .use_imm     (use_imm),
    .rs1_nonzero (rs1_nonzero),
    .csr_rd_en   (csr_rd_en),
    .exc_req     (exc_req),
    .mret_req    (mret_req),
    .zimm        (zimm),
    .rd_addr     (dec_rd_addr),
    .csr_addr    (csr_addr),
    .exc_cause   (exc_cause)
  );

  csr_execute u_csr_execute (
    .csr_op      (csr_op),
    .use_imm     (use_imm),
    .rs1_nonzero (rs1_nonzero),
    .zimm        (zimm),
    .rs1_data    (rs1_data),
    .csr_rdata   (csr_rdata),
    .csr_wen     (csr_wen),
    .csr_wdata   (csr_wdata)
  );

  csr_file u_csr_file (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .pc          (pc),
    .csr_addr    (csr_addr),
    .csr_wen     (csr_wen),
    .csr_wdata   (csr_wdata),
    .exc_req     (exc_req),
    .mret_req    (mret_req),
    .exc_cause   (exc_cause),
    .meip        (meip),
    .mtip        (mtip),
    .msip        (msip),
    .csr_rdata   (csr_rdata),
    .trap_take   (trap_take),
    .trap        (trap),
    .mret        (mret),
    .trap_vector (trap_vector),
    .mepc        (mepc)
  );

  csr_result u_csr_result (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .csr_rd_en   (csr_rd_en),
    .trap_take   (trap_take),
    .rd_addr_in  (dec_rd_addr),
    .csr_rdata   (csr_rdata),
    .trap        (trap),
    .mret        (mret),
    .trap_vector (trap_vector),
    .mepc        (mepc),
    .rd_we       (rd_we),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

// File: verification/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int num_vectors   = 30;
  localparam int words_per_vec = 10;
  localparam int num_words     = num_vectors * words_per_vec;
  localparam int cycle_limit   = 2 * num_vectors + 20;

  logic        clk;
  logic        rst;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] rs1_data;
  logic [31:0] pc;
  logic        meip;
  logic        mtip;
  logic        msip;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        redirect;
  logic [31:0] redirect_pc;

  logic [31:0] golden_mem [0:num_words-1];
  int          cycle_count = 0;

  csr_unit_top u_csr_unit_top (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_data    (rs1_data),
    .pc          (pc),
    .meip        (meip),
    .mtip        (mtip),
    .msip        (msip),
    .rd_we       (rd_we),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("simulation timed out after %0d cycles", cycle_count);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // vector words are valid instr rs1_data pc irq rd_we rd_addr rd_data redirect redirect_pc
  task automatic drive_vector(input int idx);
    int base;
    base        = idx * words_per_vec;
    instr_valid = golden_mem[base][0];
    instr       = golden_mem[base + 1];
    rs1_data    = golden_mem[base + 2];
    pc          = golden_mem[base + 3];
    meip        = golden_mem[base + 4][2];
    mtip        = golden_mem[base + 4][1];
    msip        = golden_mem[base + 4][0];
  endtask

  task automatic compare_field(input string name, input int idx,
                               input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("MISMATCH at %0t: vector %0d %s expected %h got %h",
               $time, idx, name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic check_outputs(input int idx);
    int base;
    base = idx * words_per_vec;
    compare_field("rd_we", idx, {31'h0, golden_mem[base + 5][0]}, {31'h0, rd_we});
    if (golden_mem[base + 5][0]) begin   // data only matters with a writeback
      compare_field("rd_addr", idx, golden_mem[base + 6], {27'h0, rd_addr});
      compare_field("rd_data", idx, golden_mem[base + 7], rd_data);
    end
    compare_field("redirect", idx, {31'h0, golden_mem[base + 8][0]}, {31'h0, redirect});
    if (golden_mem[base + 8][0]) begin
      compare_field("redirect_pc", idx, golden_mem[base + 9], redirect_pc);
    end
  endtask

  initial begin
    rst         = 1'b0;
    instr_valid = 1'b0;
    instr       = 32'h0;
    rs1_data    = 32'h0;
    pc          = 32'h0;
    meip        = 1'b0;
    mtip        = 1'b0;
    msip        = 1'b0;

    for (int i = 0; i < num_words; i++) begin
      golden_mem[i] = 32'hbad0_0000 ^ i;   // marker for words the file leaves unset
    end
    $readmemh("verification/csr_golden.txt", golden_mem);
    if (golden_mem[num_words - 1] == (32'hbad0_0000 ^ (num_words - 1))) begin
      $display("golden file is missing or holds fewer than %0d vectors", num_vectors);
      $display("TB FAILED");
      $fatal(1, "golden file load");
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    drive_vector(0);
    for (int i = 0; i < num_vectors; i++) begin
      @(negedge clk);
      check_outputs(i);
      if (i + 1 < num_vectors) begin
        drive_vector(i + 1);
      end else begin
        instr_valid = 1'b0;
      end
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: verilog.f
verilog/csr_pkg.sv
verilog/csr_decode.sv
verilog/csr_execute.sv
verilog/csr_file.sv
verilog/csr_result.sv
verilog/csr_unit_top.sv
verification/csr_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the csr unit testbench with verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module csr_unit_tb \
  -o csr_unit_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/csr_unit_sim > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
exit 0

// File: verification/csr_golden.txt
// valid instr rs1_data pc irq(meip,mtip,msip) | expected rd_we rd_addr rd_data redirect redirect_pc
// expected values show the outputs one cycle after the vector is applied
1 301022f3 00000000 00000100 0 1 5 40001124 0 00000000
1 f1102373 00000000 00000104 0 1 6 00000000 0 00000000
1 f14023f3 00000000 00000108 0 1 7 00000000 0 00000000
1 34051073 12345678 0000010c 0 0 0 00000000 0 00000000
1 3405a2f3 0000f000 00000110 0 1 5 12345678 0 00000000
1 34063373 00000078 00000114 0 1 6 1234f678 0 00000000
1 340fd3f3 deadbeef 00000118 0 1 7 1234f600 0 00000000
1 340572f3 00000000 0000011c 0 1 5 0000001f 0 00000000
1 34046373 00000000 00000120 0 1 6 00000015 0 00000000
1 340023f3 ffffffff 00000124 0 1 7 0000001d 0 00000000
1 340022f3 00000000 00000128 0 1 5 0000001d 0 00000000
1 300692f3 00001008 0000012c 0 1 5 00001800 0 00000000
1 30002373 00000000 00000130 0 1 6 00001808 0 00000000
1 30571073 00000400 00000134 0 0 0 00000000 0 00000000
1 00000073 00000000 00000138 0 0 0 00000000 1 00000400
1 342022f3 00000000 0000013c 0 1 5 0000000b 0 00000000
1 00000073 00000000 00000140 0 0 0 00000000 0 00000000
1 30200073 00000000 00000144 0 0 0 00000000 1 00000138
1 30002373 00000000 00000148 0 1 6 00001808 0 00000000
1 30571073 00000801 0000014c 0 0 0 00000000 0 00000000
1 30479073 00000080 00000150 2 0 0 00000000 0 00000000
1 340022f3 00000000 00000154 2 0 0 00000000 1 0000081c
1 34102373 00000000 00000158 0 1 6 00000154 0 00000000
1 342023f3 00000000 0000015c 0 1 7 80000007 0 00000000
1 30200073 00000000 00000160 0 0 0 00000000 1 00000154
1 300022f3 00000000 00000164 0 1 5 00001808 0 00000000
0 00000000 00000000 00000168 0 0 0 00000000 0 00000000
1 b0202373 00000000 0000016c 0 1 6 00000018 0 00000000
1 b02023f3 00000000 00000170 0 1 7 00000019 0 00000000
1 00000013 00000000 00000174 0 0 0 00000000 1 00000808
